//--- Makefile
# Verilator build, run and lint of the NMI control block testbench

TOP := nmi_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | awk '{ print } /Simulation PASSED/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- dv/nmi_chk.sv
// NMI block assertions
// strobe exclusivity, pin pulse length, reset values and the rom wait entry rule

`timescale 1ns/1ps
`include "nmi_defines.svh"

module nmi_chk
(
	input logic                fclk,
	input logic                rst_n,
	input logic                zpos,
	input logic                zneg,
	input logic                rfsh_fall,
	input nmi_pkg::nmi_state_t state,
	input logic                in_nmi,
	input logic                gen_nmi
);

	import nmi_pkg::*;

	localparam int PULSE_MAX = `NMI_PULSE_ZCYC * `ZCLK_DIV + 1;

	int hi_len; // consecutive fclk cycles with gen_nmi high

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			hi_len <= 0;
		else if (gen_nmi)
			hi_len <= hi_len + 1;
		else
			hi_len <= 0;
	end

	strobe_excl: assert property (@(posedge fclk) disable iff (!rst_n) !(zpos && zneg))
		else $error("zpos and zneg high in the same cycle");

	pulse_len: assert property (@(posedge fclk) disable iff (!rst_n) hi_len <= PULSE_MAX)
		else $error("gen_nmi held high for more than %0d cycles", PULSE_MAX);

	// first cycle out of reset
	reset_quiet: assert property (@(posedge fclk) $rose(rst_n) |-> !in_nmi && !gen_nmi)
		else $error("in_nmi or gen_nmi set right after reset release");

	rom_wait_hold: assert property (@(posedge fclk) disable iff (!rst_n)
		(state == NMI_ROM_WAIT && !rfsh_fall) |=> !in_nmi)
		else $error("in_nmi rose from the rom wait state without a refresh edge");

endmodule

//--- dv/nmi_input.txt
# op arg(hex) in_nmi pulses; in_nmi and pulses are expected after the operation
# FETCH arg: bit 16 csrom, bits 15:0 address; SETREQ arg: set_nmi bit; others 0
FETCH 08123 0 0
SETREQ 0 0 0
FETCH 08124 0 0
INT 0 1 1
INT 0 1 0
IMMREQ 0 1 0
CLEAR 0 1 0
FETCH 08125 1 0
FETCH 08126 0 0
IMMREQ 0 1 1
CLEAR 0 1 0
FETCH 1C010 1 0
FETCH 10123 0 0
SETREQ 1 0 0
INT 0 0 1
IMMREQ 0 0 0
FETCH 10124 0 0
FETCH 10065 0 0
FETCH 10066 1 0
FETCH 10067 1 0
CLEAR 0 1 0
FETCH 10068 1 0
FETCH 10069 0 0
SETREQ 0 0 0
INT 0 0 1
FETCH 10066 1 0

//--- dv/nmi_tb.sv
// NMI control block testbench
// replays bus and request records from a file, checks in_nmi and the NMI pin pulse

`timescale 1ns/1ps
`include "nmi_defines.svh"

module nmi_tb;

	typedef struct packed
	{
		logic [63:0] op;
		logic [16:0] arg;        // csrom and address or a request bit
		logic        exp_in;
		logic [7:0]  exp_pulses;
	} rec_t;

	logic        fclk = 1'b0;
	logic        rst_n = 1'b0;
	logic        int_start = 1'b0;
	logic [1:0]  set_nmi = 2'b11;
	logic        imm_nmi = 1'b0;
	logic        clr_nmi = 1'b0;
	logic        rfsh_n = 1'b1;
	logic        m1_n = 1'b1;
	logic        mreq_n = 1'b1;
	logic        csrom = 1'b0;
	logic [15:0] a = 16'h0000;
	logic        zclk;
	logic        in_nmi;
	logic        gen_nmi;

	rec_t        recs[$];
	int          n_rec = 0;
	int          err_cnt = 0;
	int          hi_cycles = 0;   // length of the gen_nmi pulse in progress
	int          pulse_total = 0;
	int          last_len = 0;    // last finished pulse in zclk cycles
	logic [15:0] lfsr = 16'd46913;

	nmi_top DUT (.*);

	bind nmi_top nmi_chk u_nmi_chk
	(
		.fclk      (fclk),
		.rst_n     (rst_n),
		.zpos      (zpos),
		.zneg      (zneg),
		.rfsh_fall (bus_evt.rfsh_fall),
		.state     (u_nmi_sequencer.state),
		.in_nmi    (in_nmi),
		.gen_nmi   (gen_nmi)
	);

	always #2 fclk = ~fclk;

	always @(posedge fclk)
	begin
		if (gen_nmi)
			hi_cycles <= hi_cycles + 1;
		else if (hi_cycles != 0)
		begin
			pulse_total <= pulse_total + 1;
			last_len    <= (hi_cycles + `ZCLK_DIV - 1) / `ZCLK_DIV; // partial first zclk
			hi_cycles   <= 0;
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic next_cycles(input int n);
		repeat (n) @(posedge fclk);
		#0.5;
	endtask

	task automatic idle_gap();
		logic [2:0] gap;
		gap = 3'd0;
		repeat (3)
		begin
			lfsr = lfsr_next(lfsr);
			gap  = {gap[1:0], lfsr[0]};
		end
		repeat (int'(gap) + 1) @(posedge zclk);
		#0.5;
	endtask

	// opcode fetch in T1-T2 then refresh in T3-T4
	task automatic m1_cycle(input logic [16:0] arg);
		@(posedge zclk);
		#0.5;
		a     = arg[15:0];
		csrom = arg[16];
		m1_n  = 1'b0;
		@(negedge zclk);
		#0.5;
		mreq_n = 1'b0;
		@(posedge zclk);
		@(posedge zclk);
		#0.5;
		m1_n   = 1'b1;
		mreq_n = 1'b1;
		rfsh_n = 1'b0;
		csrom  = 1'b0;
		a      = 16'h3f00; // refresh address
		@(negedge zclk);
		#0.5;
		mreq_n = 1'b0;
		@(negedge zclk);
		#0.5;
		mreq_n = 1'b1;
		@(posedge zclk);
		#0.5;
		rfsh_n = 1'b1;
	endtask

	task automatic settle();
		next_cycles(2 * `ZCLK_DIV);
		while (gen_nmi || hi_cycles != 0)
			next_cycles(1);
	endtask

	task automatic run_record(input int idx, input rec_t r);
		int    base;
		string name;
		base = pulse_total;
		name = $sformatf("%0s#%0d", r.op, idx);
		case (r.op)
			64'("FETCH"):
				m1_cycle(r.arg);
			64'("SETREQ"):
			begin
				set_nmi[r.arg[0]] = 1'b0; // falling edge is the request
				next_cycles(`ZCLK_DIV);
				set_nmi[r.arg[0]] = 1'b1;
			end
			64'("IMMREQ"):
			begin
				imm_nmi = 1'b1;
				next_cycles(`ZCLK_DIV);
				imm_nmi = 1'b0;
			end
			64'("INT"):
			begin
				int_start = 1'b1;
				next_cycles(1);
				int_start = 1'b0;
			end
			64'("CLEAR"):
			begin
				clr_nmi = 1'b1;
				next_cycles(1);
				clr_nmi = 1'b0;
			end
			default:
			begin
				$display("record %0d has an unknown operation", idx);
				err_cnt++;
			end
		endcase
		settle();
		check({name, " in_nmi"}, 32'(r.exp_in), 32'(in_nmi));
		check({name, " pulses"}, 32'(r.exp_pulses), pulse_total - base);
		if (pulse_total != base)
			check({name, " pulse zclk"}, `NMI_PULSE_ZCYC, last_len);
	endtask

	initial
	begin
		wait (n_rec != 0);
		#(n_rec * 64 * 4);
		$display("timeout, the records did not finish within %0d ns", n_rec * 256);
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		int               fd;
		int               code;
		int               ein;
		int               epul;
		logic [63:0]      op;
		logic [16:0]      arg;
		logic [8*128-1:0] rest;
		realtime          t0;
		rec_t             r;

		fd = $fopen("dv/nmi_input.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open dv/nmi_input.txt");
			err_cnt++;
		end
		else
		begin
			while ($fscanf(fd, "%s", op) == 1)
			begin
				if (op == 64'("#"))
					code = $fgets(rest, fd); // comment line
				else
				begin
					code = $fscanf(fd, "%h %d %d", arg, ein, epul);
					if (code != 3)
					begin
						$display("record %0d in the input file is missing fields",
							recs.size());
						err_cnt++;
					end
					else
					begin
						r.op         = op;
						r.arg        = arg;
						r.exp_in     = ein[0];
						r.exp_pulses = epul[7:0];
						recs.push_back(r);
					end
				end
			end
			$fclose(fd);
		end
		n_rec = recs.size();
		if (n_rec == 0)
		begin
			$display("no records were read from the input file");
			err_cnt++;
		end

		next_cycles(3);
		rst_n = 1'b1;
		next_cycles(1);
		check("reset in_nmi", 0, 32'(in_nmi));
		check("reset gen_nmi", 0, 32'(gen_nmi));
		@(posedge zclk);
		t0 = $realtime;
		@(posedge zclk);
		check("zclk period ns", `ZCLK_DIV * 4, int'($realtime - t0));
		#0.5;

		for (int i = 0; i < n_rec; i++)
		begin
			run_record(i, recs[i]);
			idle_gap();
		end

		$display("records %0d, errors %0d", n_rec, err_cnt);
		if (err_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- sources.f
+incdir+src
src/nmi_pkg.sv
src/zclk_phase.sv
src/bus_sampler.sv
src/nmi_request.sv
src/nmi_sequencer.sv
src/nmi_top.sv
dv/nmi_chk.sv
dv/nmi_tb.sv

//--- src/bus_sampler.sv
// Z80 bus sampler
// tracks where the last opcode fetch came from and flags refresh falling edges

`timescale 1ns/1ps
`include "nmi_defines.svh"

module bus_sampler
(
	input  logic               fclk,
	input  logic               rst_n,
	input  logic               zpos,
	input  logic               zneg,
	input  logic               m1_n,
	input  logic               mreq_n,
	input  logic               rfsh_n,
	input  logic               csrom,
	input  logic [15:0]        a,
	output nmi_pkg::zbus_evt_t bus_evt
);

	import nmi_pkg::*;

	logic       m1_n_r;     // sampled on zpos
	logic       mreq_n_r;   // sampled on zneg
	logic [1:0] rfsh_n_r;   // [0] on zpos, [1] one fclk later
	logic       fetch;
	logic       fetch_r;
	logic       fetch_first;
	logic       last_rom;
	logic       last_vec;
	logic       rfsh_fall;

	// opcode fetch while both m1 and mreq are low
	assign fetch       = ~(m1_n_r | mreq_n_r);
	assign fetch_first = fetch & ~fetch_r;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			m1_n_r   <= 1'b1;
			mreq_n_r <= 1'b1;
			rfsh_n_r <= 2'b11;
			fetch_r  <= 1'b0;
		end
		else
		begin
			if (zpos)
			begin
				m1_n_r      <= m1_n;
				rfsh_n_r[0] <= rfsh_n;
			end
			if (zneg)
				mreq_n_r <= mreq_n;
			rfsh_n_r[1] <= rfsh_n_r[0];
			fetch_r     <= fetch;
		end
	end

	// address and chip select are stable by the time the fetch is seen
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			last_rom  <= 1'b0;
			last_vec  <= 1'b0;
			rfsh_fall <= 1'b0;
		end
		else
		begin
			if (fetch_first)
			begin
				last_rom <= csrom && (a[15:14] == `ROM_WINDOW);
				last_vec <= (a == `NMI_VECTOR);
			end
			rfsh_fall <= rfsh_n_r[1] & ~rfsh_n_r[0]; // high for one fclk only
		end
	end

	assign bus_evt.last_rom  = last_rom;
	assign bus_evt.last_vec  = last_vec;
	assign bus_evt.rfsh_fall = rfsh_fall;

endmodule

//--- src/nmi_defines.svh
// NMI control block constants
// Z80 clock divide, NMI pin pulse timing and address decode values

`ifndef NMI_DEFINES_SVH
`define NMI_DEFINES_SVH

// fclk cycles per zclk period, must be even
`define ZCLK_DIV        4

// gen_nmi length in zpos strobes
`define NMI_PULSE_ZCYC  4

// refresh falling edges between clr_nmi and the in_nmi drop
`define NMI_CLR_RFSH    2

`define NMI_VECTOR      16'h0066
`define ROM_WINDOW      2'b00   // a[15:14] of the rom window

`endif

//--- src/nmi_pkg.sv
// NMI control types
// bus event bundle between sampler and sequencer, sequencer state encoding

package nmi_pkg;

	// events seen on the z80 bus, one bundle per fclk cycle
	typedef struct packed
	{
		logic last_rom;  // latest opcode fetch hit the rom window
		logic last_vec;  // latest opcode fetch was at the nmi vector
		logic rfsh_fall; // one cycle pulse per refresh falling edge
	} zbus_evt_t;

	// NMI_ROM_WAIT holds off the page switch until the vector fetch
	// so the rom handler stub at 0066 still runs from rom
	typedef enum logic [1:0]
	{
		NMI_IDLE     = 2'd0,
		NMI_ROM_WAIT = 2'd1,
		NMI_ACTIVE   = 2'd2
	} nmi_state_t;

endpackage

//--- src/nmi_request.sv
// NMI request stage
// edge-detects set and immediate requests and issues a single start pulse

`timescale 1ns/1ps

module nmi_request
(
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       int_start,
	input  logic [1:0] set_nmi,   // active-low going requests, spi slave and port
	input  logic       imm_nmi,   // breakpoint request, acts on the rising edge
	output logic       nmi_start
);

	logic [1:0] set_nmi_r [2];   // two register stages per request bit
	logic [1:0] imm_nmi_r;
	logic       set_fall;
	logic       imm_rise;
	logic       pending;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			set_nmi_r[0] <= 2'b00;
			set_nmi_r[1] <= 2'b00;
			imm_nmi_r    <= 2'b00;
		end
		else
		begin
			set_nmi_r[0] <= set_nmi;
			set_nmi_r[1] <= set_nmi_r[0];
			imm_nmi_r    <= {imm_nmi_r[0], imm_nmi};
		end
	end

	assign set_fall = |(set_nmi_r[1] & ~set_nmi_r[0]);
	assign imm_rise = imm_nmi_r[0] & ~imm_nmi_r[1];

	// a set request waits here for the next INT
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			pending <= 1'b0;
		else if (int_start)
			pending <= 1'b0;
		else if (set_fall)
			pending <= 1'b1;
	end

	assign nmi_start = (pending & int_start) | imm_rise;

endmodule

//--- src/nmi_sequencer.sv
// NMI sequencer
// times the NMI pin pulse and raises in_nmi now or after the 0066 fetch,
// then drops it a set number of refresh cycles after a clear strobe

`timescale 1ns/1ps
`include "nmi_defines.svh"

module nmi_sequencer
(
	input  logic               fclk,
	input  logic               rst_n,
	input  logic               zpos,
	input  logic               nmi_start,
	input  logic               clr_nmi,
	input  nmi_pkg::zbus_evt_t bus_evt,
	output logic               in_nmi,
	output logic               gen_nmi
);

	import nmi_pkg::*;

	// bit 2 of the pulse counter is the pin drive, so start above 3
	localparam logic [2:0] PULSE_LOAD = 3'(4 + `NMI_PULSE_ZCYC - 1);
	localparam logic [1:0] CLR_LOAD   = 2'(`NMI_CLR_RFSH + 1);

	nmi_state_t state;
	nmi_state_t state_next;
	logic [2:0] pulse_cnt;
	logic [1:0] clr_cnt;    // 0 means no clear in progress
	logic       clr_done;
	logic       start_ok;

	assign clr_done = (clr_cnt == 2'd1);
	assign start_ok = nmi_start && (state == NMI_IDLE) && !clr_done;

	always_comb
	begin
		state_next = state;
		if (clr_done)
			state_next = NMI_IDLE;
		else
		begin
			case (state)
				NMI_IDLE:
					if (start_ok)
						state_next = bus_evt.last_rom ? NMI_ROM_WAIT : NMI_ACTIVE;
				NMI_ROM_WAIT:
					if (bus_evt.rfsh_fall && bus_evt.last_vec)
						state_next = NMI_ACTIVE; // handler now past 0066
				NMI_ACTIVE:
					state_next = NMI_ACTIVE;
				default:
					state_next = NMI_IDLE;
			endcase
		end
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			state <= NMI_IDLE;
		else
			state <= state_next;
	end

	// pin pulse, counted in z80 clocks
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			pulse_cnt <= 3'd0;
		else if (start_ok)
			pulse_cnt <= PULSE_LOAD;
		else if (pulse_cnt[2] && zpos)
			pulse_cnt <= pulse_cnt - 3'd1;
	end

	// clear countdown in refresh cycles, ends at 1 and parks at 0
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			clr_cnt <= 2'd0;
		else if (clr_nmi)
			clr_cnt <= CLR_LOAD;
		else if (clr_done)
			clr_cnt <= 2'd0;
		else if (bus_evt.rfsh_fall && (clr_cnt > 2'd1))
			clr_cnt <= clr_cnt - 2'd1;
	end

	assign in_nmi  = (state == NMI_ACTIVE); // maps the last ram page to 0000-3FFF
	assign gen_nmi = pulse_cnt[2];

endmodule

//--- src/nmi_top.sv
// NMI control block top
// phase generator feeding the bus sampler, request stage and sequencer

`timescale 1ns/1ps

module nmi_top
(
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        int_start,
	input  logic [1:0]  set_nmi,
	input  logic        imm_nmi,
	input  logic        clr_nmi,
	input  logic        rfsh_n,
	input  logic        m1_n,
	input  logic        mreq_n,
	input  logic        csrom,
	input  logic [15:0] a,
	output logic        zclk,
	output logic        in_nmi,
	output logic        gen_nmi
);

	import nmi_pkg::*;

	logic      zpos;
	logic      zneg;
	logic      nmi_start;
	zbus_evt_t bus_evt;

	zclk_phase u_zclk_phase (
		.fclk  (fclk),
		.rst_n (rst_n),
		.zclk  (zclk),
		.zpos  (zpos),
		.zneg  (zneg)
	);

	bus_sampler u_bus_sampler (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.zpos    (zpos),
		.zneg    (zneg),
		.m1_n    (m1_n),
		.mreq_n  (mreq_n),
		.rfsh_n  (rfsh_n),
		.csrom   (csrom),
		.a       (a),
		.bus_evt (bus_evt)
	);

	nmi_request u_nmi_request (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.int_start (int_start),
		.set_nmi   (set_nmi),
		.imm_nmi   (imm_nmi),
		.nmi_start (nmi_start)
	);

	nmi_sequencer u_nmi_sequencer (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.zpos      (zpos),
		.nmi_start (nmi_start),
		.clr_nmi   (clr_nmi),
		.bus_evt   (bus_evt),
		.in_nmi    (in_nmi),
		.gen_nmi   (gen_nmi)
	);

endmodule

//--- src/zclk_phase.sv
// Z80 clock phase generator
// divides fclk into zclk and marks its edges with one-cycle zpos/zneg strobes

`timescale 1ns/1ps
`include "nmi_defines.svh"

module zclk_phase
(
	input  logic fclk,
	input  logic rst_n,
	output logic zclk,
	output logic zpos,
	output logic zneg
);

	localparam int CW = $clog2(`ZCLK_DIV);
	localparam logic [CW-1:0] RISE_AT = CW'(`ZCLK_DIV / 2 - 1);
	localparam logic [CW-1:0] FALL_AT = CW'(`ZCLK_DIV - 1);

	logic [CW-1:0] div_cnt;
	logic          rise_next; // zclk goes high on this edge
	logic          fall_next;

	assign rise_next = (div_cnt == RISE_AT);
	assign fall_next = (div_cnt == FALL_AT);

	// strobes decoded one cycle early so they line up with the zclk edge
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			div_cnt <= '0;
			zclk    <= 1'b0;
			zpos    <= 1'b0;
			zneg    <= 1'b0;
		end
		else
		begin
			div_cnt <= fall_next ? '0 : div_cnt + 1'b1; // wraps once per zclk period
			if (rise_next)
				zclk <= 1'b1;
			else if (fall_next)
				zclk <= 1'b0;
			zpos <= rise_next;
			zneg <= fall_next;
		end
	end

endmodule
